// ==== fifo_net.f ====
verilog/fifo_net_pkg.sv
verilog/word_stream_if.sv
verilog/sync_fifo.sv
verilog/rx_router.sv
verilog/cmd_regfile.sv
verilog/tx_arbiter.sv
verilog/fifo_net_top.sv
sim/tb_fifo_net.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the host link router testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_fifo_net -f fifo_net.f \
    && ./obj_dir/Vtb_fifo_net | tee /dev/stderr | grep -qx "TB PASSED" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== sim/tb_fifo_net.sv ====
// Host link router testbench
`default_nettype none

module tb_fifo_net;

    localparam logic [7:0] DEV_ID     = 8'd3;
    localparam logic [7:0] VER_MAJ    = 8'd4;
    localparam logic [7:0] VER_MIN    = 8'd1;
    localparam int         MAX_CYCLES = 4000;   // Roughly ten times the stimulus

    // Where a host word is expected to show up
    localparam logic [1:0] TO_NONE = 2'd0;
    localparam logic [1:0] TO_TLP  = 2'd1;
    localparam logic [1:0] TO_TX   = 2'd2;

    typedef struct packed {
        logic [1:0]  dest;
        logic        uptime;                    // Only the address is predictable
        logic [1:0]  ctx;
        logic [31:0] data;
    } exp_t;

    logic        clk;
    logic        rst            = 1'b1;
    logic [63:0] i_rx_data      = '0;
    logic        i_rx_valid     = 1'b0;
    logic [31:0] i_tlp_in_data  = '0;
    logic        i_tlp_in_last  = 1'b0;
    logic        i_tlp_in_valid = 1'b0;
    logic        i_tx_ready     = 1'b0;
    logic [31:0] o_tlp_data;
    logic        o_tlp_last;
    logic        o_tlp_valid;
    logic        o_tlp_in_ready;
    logic [31:0] o_tx_data;
    logic [1:0]  o_tx_ctx;
    logic        o_tx_valid;
    logic [15:0] o_subsys_vend_id;
    logic [15:0] o_vend_id;
    logic [15:0] o_dev_id;
    logic [7:0]  o_rev_id;

    exp_t        tlp_q[$];                      // Expected on o_tlp_*
    exp_t        tx_q[$];                       // Expected on o_tx_*
    logic [32:0] tlp_in_q[$];                   // {last, data} for the PCIe side
    logic [15:0] uptime_seen[$];
    logic [7:0]  rw_shadow[16];                 // Read-write space by byte
    exp_t        tlp_exp;
    exp_t        tx_exp;
    logic [32:0] tlp_next;
    logic        hold_ready = 1'b0;
    int          errors     = 0;
    int          checks     = 0;
    int          cycles     = 0;

    // Read addresses with uptime first and last
    logic [15:0] rd_addrs[15] = '{16'h0010, 16'h0000, 16'h0004, 16'h0008, 16'h000A,
                                  16'h8000, 16'h8004, 16'h8008, 16'h800A, 16'h800C,
                                  16'h800E, 16'h0020, 16'h8010, 16'h7FFE, 16'h0010};

    fifo_net_top #(
        .DEVICE_ID     (DEV_ID),
        .VERSION_MAJOR (VER_MAJ),
        .VERSION_MINOR (VER_MIN),
        .FIFO_DEPTH    (16)
    ) dut (
        .clk              (clk),
        .rst              (rst),
        .i_rx_data        (i_rx_data),
        .i_rx_valid       (i_rx_valid),
        .o_tlp_data       (o_tlp_data),
        .o_tlp_last       (o_tlp_last),
        .o_tlp_valid      (o_tlp_valid),
        .i_tlp_in_data    (i_tlp_in_data),
        .i_tlp_in_last    (i_tlp_in_last),
        .i_tlp_in_valid   (i_tlp_in_valid),
        .o_tlp_in_ready   (o_tlp_in_ready),
        .o_tx_data        (o_tx_data),
        .o_tx_ctx         (o_tx_ctx),
        .o_tx_valid       (o_tx_valid),
        .i_tx_ready       (i_tx_ready),
        .o_subsys_vend_id (o_subsys_vend_id),
        .o_vend_id        (o_vend_id),
        .o_dev_id         (o_dev_id),
        .o_rev_id         (o_rev_id)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    function automatic logic [7:0] reg_byte(input logic rw_space, input int a);
        if (rw_space)
            return (a < 16) ? rw_shadow[a] : 8'h00;
        case (a)
            0:       return 8'h89;              // Magic ab89 with low byte first
            1:       return 8'hab;
            4:       return 8'd24;              // 192 bits
            8:       return VER_MAJ;
            9:       return VER_MIN;
            10:      return DEV_ID;
            default: return 8'h00;              // Uptime not modeled
        endcase
    endfunction

    function automatic exp_t expect_word(input logic [63:0] w);
        exp_t        e;
        int          a;
        logic        rw_space;
        logic [15:0] value;
        logic [15:0] mask;
        e        = '0;
        a        = int'(w[30:16]);
        rw_space = w[31];
        value    = {w[55:48], w[63:56]};        // Byte 6 is the high byte
        mask     = {w[39:32], w[47:40]};
        if (w[7:0] != 8'h77)
            return e;                           // Bad tag
        case (w[9:8])
            2'b00:
            begin
                e.dest = TO_TLP;
                e.data = w[63:32];
                e.ctx  = {1'b0, w[10]};
            end
            2'b10:
            begin
                e.dest = TO_TX;                 // Loopback keeps its ctx
                e.data = w[63:32];
                e.ctx  = w[11:10];
            end
            2'b11:
            begin
                if (w[12])
                begin
                    e.dest   = TO_TX;
                    e.data   = {w[31:16], reg_byte(rw_space, a), reg_byte(rw_space, a + 1)};
                    e.uptime = !rw_space && a >= 15 && a <= 23;
                end
                // Write lands after the read
                if (w[13] && rw_space && !w[30])
                    for (int i = 0; i < 2; i++)
                        if (a + i < 16)
                            rw_shadow[a + i] = (rw_shadow[a + i] & ~mask[8*i +: 8])
                                             | (value[8*i +: 8] & mask[8*i +: 8]);
            end
            default: ;                          // CFG
        endcase
        return e;
    endfunction

    function automatic logic [15:0] shadow16(input int a);
        return {rw_shadow[a + 1], rw_shadow[a]};
    endfunction

    function automatic logic [63:0] host_word(input logic [1:0] typ, input logic [1:0] ctx,
                                              input logic [31:0] payload);
        return {payload, 20'h0, ctx, typ, 8'h77};
    endfunction

    function automatic logic [63:0] cmd_word(input logic rd, input logic wr,
                                             input logic [15:0] addr, input logic [15:0] value,
                                             input logic [15:0] mask);
        return {value[7:0], value[15:8], mask[7:0], mask[15:8], addr,
                2'b00, wr, rd, 2'b00, 2'b11, 8'h77};
    endfunction

    // ------------------------------------------------------------------------
    // Tasks
    // ------------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        if (got !== want)
        begin
            $display("MISMATCH %s: got %h expected %h", name, got, want);
            errors++;
        end
    endtask

    task automatic send(input logic [63:0] w);
        exp_t e;
        e = expect_word(w);
        if (e.dest == TO_TLP)
            tlp_q.push_back(e);
        else if (e.dest == TO_TX)
            tx_q.push_back(e);
        @(posedge clk);
        i_rx_data  <= w;
        i_rx_valid <= 1'b1;
    endtask

    task automatic idle();
        @(posedge clk);
        i_rx_valid <= 1'b0;
    endtask

    task automatic drain();
        while (tx_q.size() != 0 || tlp_q.size() != 0)
            @(posedge clk);
        repeat (8) @(posedge clk);              // Catch stray words
    endtask

    // ------------------------------------------------------------------------
    // Drivers and comparison
    // ------------------------------------------------------------------------
    always @(posedge clk)
        i_tx_ready <= hold_ready ? 1'b0 : (($urandom % 4) != 0);  // Random gaps

    // PCIe side source holds each word until taken
    always @(posedge clk)
    begin
        if (rst)
            i_tlp_in_valid <= 1'b0;
        else if (!i_tlp_in_valid || o_tlp_in_ready)
        begin
            if (tlp_in_q.size() != 0)
            begin
                tlp_next = tlp_in_q.pop_front();
                i_tlp_in_data  <= tlp_next[31:0];
                i_tlp_in_last  <= tlp_next[32];
                i_tlp_in_valid <= 1'b1;
            end
            else
                i_tlp_in_valid <= 1'b0;
        end
    end

    always @(posedge clk)
    begin
        if (!rst && o_tlp_valid)
        begin
            if (tlp_q.size() == 0)
            begin
                $display("Unexpected word on o_tlp_data: %h", o_tlp_data);
                errors++;
            end
            else
            begin
                tlp_exp = tlp_q.pop_front();
                check_value("o_tlp_data", o_tlp_data, tlp_exp.data);
                check_value("o_tlp_last", 32'(o_tlp_last), 32'(tlp_exp.ctx[0]));
            end
        end
    end

    always @(posedge clk)
    begin
        if (!rst && o_tx_valid && i_tx_ready)
        begin
            if (tx_q.size() == 0)
            begin
                $display("Unexpected word on o_tx_data: %h", o_tx_data);
                errors++;
            end
            else
            begin
                tx_exp = tx_q.pop_front();
                if (tx_exp.uptime)
                begin
                    check_value("o_tx_data[31:16]", 32'(o_tx_data[31:16]),
                                32'(tx_exp.data[31:16]));
                    uptime_seen.push_back({o_tx_data[7:0], o_tx_data[15:8]});
                end
                else
                    check_value("o_tx_data", o_tx_data, tx_exp.data);
                check_value("o_tx_ctx", 32'(o_tx_ctx), 32'(tx_exp.ctx));
            end
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
        begin
            $display("Timeout after %0d cycles with %0d words still expected",
                     cycles, tx_q.size() + tlp_q.size());
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("TB FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    initial
    begin
        logic [32:0] tlp_word;
        void'($urandom(28));
        for (int i = 0; i < 16; i++)
            rw_shadow[i] = 8'h00;
        rw_shadow[0]  = 8'hcd;                  // Magic efcd
        rw_shadow[1]  = 8'hef;
        rw_shadow[4]  = 8'd16;                  // Byte count
        rw_shadow[8]  = 8'hee;
        rw_shadow[9]  = 8'h10;
        rw_shadow[10] = 8'hee;
        rw_shadow[11] = 8'h10;
        rw_shadow[12] = 8'h66;
        rw_shadow[13] = 8'h06;
        rw_shadow[14] = 8'h02;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // Idle outputs and identity defaults
        check_value("o_tx_valid", 32'(o_tx_valid), 32'h0);
        check_value("o_tlp_valid", 32'(o_tlp_valid), 32'h0);
        check_value("o_subsys_vend_id", 32'(o_subsys_vend_id), 32'(shadow16(8)));
        check_value("o_vend_id", 32'(o_vend_id), 32'(shadow16(10)));
        check_value("o_dev_id", 32'(o_dev_id), 32'(shadow16(12)));
        check_value("o_rev_id", 32'(o_rev_id), 32'(rw_shadow[14]));

        // TLP host words with one broken tag
        for (int n = 0; n < 6; n++)
            send(host_word(2'b00, 2'($urandom), $urandom));
        send(host_word(2'b00, 2'b01, $urandom) ^ 64'h1);
        idle();
        drain();

        // Loopback mixed with CFG and bad tags
        for (int n = 0; n < 8; n++)
        begin
            send(host_word(2'b10, 2'($urandom), $urandom));
            if (n % 3 == 0)
                send(host_word(2'b01, 2'($urandom), $urandom));
            if (n % 3 == 1)
                send(host_word(2'b10, 2'($urandom), $urandom) ^ 64'h1);
        end
        idle();
        drain();

        // Register reads
        foreach (rd_addrs[k])
            send(cmd_word(1'b1, 1'b0, rd_addrs[k], 16'h0, 16'h0));
        idle();
        drain();
        if (uptime_seen.size() != 2 || uptime_seen[1] <= uptime_seen[0])
        begin
            $display("Uptime did not advance between the two reads");
            errors++;
        end

        // Masked writes, blocked writes, read with write
        send(cmd_word(1'b0, 1'b1, 16'h800A, 16'h1234, 16'h00FF));
        send(cmd_word(1'b0, 1'b1, 16'h800C, 16'hBEEF, 16'hF0F0));
        send(cmd_word(1'b0, 1'b1, 16'hC00A, 16'hFFFF, 16'hFFFF));   // Bit 14 set
        send(cmd_word(1'b0, 1'b1, 16'h0000, 16'h0000, 16'hFFFF));   // Read-only space
        send(cmd_word(1'b1, 1'b1, 16'h800E, 16'h0055, 16'h00FF));   // Old value read
        send(cmd_word(1'b1, 1'b0, 16'h800A, 16'h0, 16'h0));
        send(cmd_word(1'b1, 1'b0, 16'h800C, 16'h0, 16'h0));
        send(cmd_word(1'b1, 1'b0, 16'h800E, 16'h0, 16'h0));
        send(cmd_word(1'b1, 1'b0, 16'h8000, 16'h0, 16'h0));         // Magic untouched
        idle();
        drain();
        check_value("o_vend_id", 32'(o_vend_id), 32'(shadow16(10)));
        check_value("o_dev_id", 32'(o_dev_id), 32'(shadow16(12)));
        check_value("o_subsys_vend_id", 32'(o_subsys_vend_id), 32'(shadow16(8)));
        check_value("o_rev_id", 32'(o_rev_id), 32'(rw_shadow[14]));

        // Every class queued under back-pressure then released
        hold_ready <= 1'b1;
        repeat (3) @(posedge clk);
        for (int n = 0; n < 6; n++)
        begin
            tlp_word = {1'($urandom), $urandom};
            tlp_in_q.push_back(tlp_word);
            tx_q.push_back(exp_t'{TO_TX, 1'b0, {1'b0, tlp_word[32]}, tlp_word[31:0]});
        end
        repeat (2) @(posedge clk);
        for (int n = 0; n < 8; n++)
            send(host_word(2'b10, 2'($urandom), $urandom));
        for (int n = 0; n < 6; n++)
            send(cmd_word(1'b1, 1'b0, 16'h8000 | 16'($urandom % 16), 16'h0, 16'h0));
        idle();
        repeat (30) @(posedge clk);             // Let responses settle
        check_value("o_tlp_in_ready", 32'(o_tlp_in_ready), 32'h0);
        hold_ready <= 1'b0;
        drain();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/cmd_regfile.sv ====
// Command register file
`default_nettype none

module cmd_regfile #(
    parameter logic [7:0] DEVICE_ID     = 8'd0,
    parameter logic [7:0] VERSION_MAJOR = 8'd0,
    parameter logic [7:0] VERSION_MINOR = 8'd0,
    parameter int         FIFO_DEPTH    = 16
) (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           i_cmd_wr_en,
    input  wire  [fifo_net_pkg::RX_W-1:0] i_cmd_din,
    word_stream_if.source                 resp_s,
    output logic [15:0]                   o_subsys_vend_id,
    output logic [15:0]                   o_vend_id,
    output logic [15:0]                   o_dev_id,
    output logic [7:0]                    o_rev_id
);

    localparam int CW      = fifo_net_pkg::CTX_W;
    localparam int RO_BITS = fifo_net_pkg::RO_BITS;
    localparam int RW_BITS = fifo_net_pkg::RW_BITS;

    word_stream_if #(.DW(fifo_net_pkg::RX_W)) cmd_s ();

    logic [RO_BITS-1:0]            ro;
    logic [RW_BITS-1:0]            rw;
    logic [63:0]                   uptime;
    logic                          pop;
    logic [15:0]                   addr;
    logic [17:0]                   bit_addr;   // Byte address times 8
    logic [15:0]                   wr_value;
    logic [15:0]                   wr_mask;
    logic [RO_BITS-1:0]            ro_sh;
    logic [RW_BITS-1:0]            rw_sh;
    logic [15:0]                   rd_value;
    logic [RW_BITS-1:0]            wr_mask_full;
    logic [RW_BITS-1:0]            wr_value_full;
    logic                          is_read;
    logic                          is_write;
    logic                          resp_afull;
    logic                          resp_wr_en;
    logic [fifo_net_pkg::TX_W-1:0] resp_word;

    // Read-write defaults
    function automatic logic [RW_BITS-1:0] rw_init();
        logic [RW_BITS-1:0] v;
        v = '0;
        v[fifo_net_pkg::RW_OFS_MAGIC*8 +: 16]          = fifo_net_pkg::RW_MAGIC;
        v[fifo_net_pkg::RW_OFS_BYTECOUNT*8 +: 32]      = RW_BITS / 8;
        v[fifo_net_pkg::RW_OFS_SUBSYS_VEND_ID*8 +: 16] = fifo_net_pkg::RW_DEF_SUBSYS_VEND_ID;
        v[fifo_net_pkg::RW_OFS_VEND_ID*8 +: 16]        = fifo_net_pkg::RW_DEF_VEND_ID;
        v[fifo_net_pkg::RW_OFS_DEV_ID*8 +: 16]         = fifo_net_pkg::RW_DEF_DEV_ID;
        v[fifo_net_pkg::RW_OFS_REV_ID*8 +: 8]          = fifo_net_pkg::RW_DEF_REV_ID;
        return v;
    endfunction

    // ------------------------------------------------------------------------
    // Command queue, popped while responses have room
    // ------------------------------------------------------------------------
    sync_fifo #(.WIDTH(fifo_net_pkg::RX_W + CW), .DEPTH(FIFO_DEPTH)) u_cmd_fifo (
        .clk           (clk),
        .rst           (rst),
        .i_wr_en       (i_cmd_wr_en),
        .i_din         ({{CW{1'b0}}, i_cmd_din}),
        .o_full        (),
        .o_almost_full (),
        .out_s         (cmd_s)
    );

    assign cmd_s.ready = ~resp_afull;
    assign pop         = cmd_s.valid & cmd_s.ready;

    // Field decode
    assign addr     = cmd_s.data[fifo_net_pkg::CMD_ADDR_LSB +: 16];
    assign bit_addr = {addr[14:0], 3'b000};
    assign wr_value = {cmd_s.data[55:48], cmd_s.data[63:56]};   // Bytes 6,7
    assign wr_mask  = {cmd_s.data[39:32], cmd_s.data[47:40]};   // Bytes 4,5
    assign is_read  = pop & cmd_s.data[fifo_net_pkg::CMD_READ_BIT];
    assign is_write = pop & cmd_s.data[fifo_net_pkg::CMD_WRITE_BIT]
                    & addr[fifo_net_pkg::ADDR_RW_BIT] & ~addr[fifo_net_pkg::ADDR_NOWR_BIT];

    // Read-only space
    always_comb
    begin
        ro = '0;
        ro[fifo_net_pkg::RO_OFS_MAGIC*8 +: 16]     = fifo_net_pkg::RO_MAGIC;
        ro[fifo_net_pkg::RO_OFS_BYTECOUNT*8 +: 32] = RO_BITS / 8;
        ro[fifo_net_pkg::RO_OFS_VER_MAJOR*8 +: 8]  = VERSION_MAJOR;
        ro[fifo_net_pkg::RO_OFS_VER_MINOR*8 +: 8]  = VERSION_MINOR;
        ro[fifo_net_pkg::RO_OFS_DEVICE_ID*8 +: 8]  = DEVICE_ID;
        ro[fifo_net_pkg::RO_OFS_UPTIME*8 +: 64]    = uptime;
    end

    // Shifts fill with zeros, so out of range reads give 0
    assign ro_sh    = ro >> bit_addr;
    assign rw_sh    = rw >> bit_addr;
    assign rd_value = addr[fifo_net_pkg::ADDR_RW_BIT] ? rw_sh[15:0] : ro_sh[15:0];

    // Masked write lanes
    assign wr_mask_full  = {{(RW_BITS-16){1'b0}}, wr_mask} << bit_addr;
    assign wr_value_full = {{(RW_BITS-16){1'b0}}, wr_value} << bit_addr;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rw         <= rw_init();
            uptime     <= '0;
            resp_wr_en <= 1'b0;
        end
        else
        begin
            uptime     <= uptime + 1'b1;
            resp_wr_en <= is_read;
            if (is_write)
                rw <= (rw & ~wr_mask_full) | (wr_value_full & wr_mask_full); // Read sees old
        end
    end

    // Response, address then byte-swapped value
    always_ff @(posedge clk)
    begin
        if (is_read)
            resp_word <= {addr, rd_value[7:0], rd_value[15:8]};
    end

    sync_fifo #(.WIDTH(fifo_net_pkg::TX_W + CW), .DEPTH(FIFO_DEPTH)) u_resp_fifo (
        .clk           (clk),
        .rst           (rst),
        .i_wr_en       (resp_wr_en),
        .i_din         ({{CW{1'b0}}, resp_word}),
        .o_full        (),
        .o_almost_full (resp_afull),
        .out_s         (resp_s)
    );

    // PCIe identity
    assign o_subsys_vend_id = rw[fifo_net_pkg::RW_OFS_SUBSYS_VEND_ID*8 +: 16];
    assign o_vend_id        = rw[fifo_net_pkg::RW_OFS_VEND_ID*8 +: 16];
    assign o_dev_id         = rw[fifo_net_pkg::RW_OFS_DEV_ID*8 +: 16];
    assign o_rev_id         = rw[fifo_net_pkg::RW_OFS_REV_ID*8 +: 8];

endmodule

`default_nettype wire

// ==== verilog/fifo_net_pkg.sv ====
// Host link router definitions
`default_nettype none

package fifo_net_pkg;

    // Word widths
    localparam int RX_W  = 64;              // Host link word
    localparam int TX_W  = 32;              // Returned word payload
    localparam int CTX_W = 2;               // Context bits beside payload

    localparam logic [7:0] RX_MAGIC = 8'h77;   // Tag byte, bits 7:0

    // Host word type, bits 9:8
    typedef enum logic [1:0] {
        RX_TLP  = 2'b00,
        RX_CFG  = 2'b01,                    // Not served, dropped
        RX_LOOP = 2'b10,
        RX_CMD  = 2'b11
    } rx_type_e;

    // Return path source select
    typedef enum logic [1:0] {
        SRC_NONE,
        SRC_TLP,
        SRC_LOOP,
        SRC_CMD
    } tx_src_e;

    // ------------------------------------------------------------------------
    // Register file layout, byte offsets
    // ------------------------------------------------------------------------
    localparam logic [15:0] RO_MAGIC = 16'hab89;
    localparam logic [15:0] RW_MAGIC = 16'hefcd;
    localparam int RO_BITS = 192;
    localparam int RW_BITS = 128;

    localparam int RO_OFS_MAGIC     = 'h00;
    localparam int RO_OFS_BYTECOUNT = 'h04;
    localparam int RO_OFS_VER_MAJOR = 'h08;
    localparam int RO_OFS_VER_MINOR = 'h09;
    localparam int RO_OFS_DEVICE_ID = 'h0A;
    localparam int RO_OFS_UPTIME    = 'h10;   // 64 bit tick count

    localparam int RW_OFS_MAGIC          = 'h00;
    localparam int RW_OFS_BYTECOUNT      = 'h04;
    localparam int RW_OFS_SUBSYS_VEND_ID = 'h08;
    localparam int RW_OFS_VEND_ID        = 'h0A;
    localparam int RW_OFS_DEV_ID         = 'h0C;
    localparam int RW_OFS_REV_ID         = 'h0E;

    // PCIe identity defaults
    localparam logic [15:0] RW_DEF_SUBSYS_VEND_ID = 16'h10EE;
    localparam logic [15:0] RW_DEF_VEND_ID        = 16'h10EE;
    localparam logic [15:0] RW_DEF_DEV_ID         = 16'h0666;
    localparam logic [7:0]  RW_DEF_REV_ID         = 8'h02;

    // Command word fields
    localparam int CMD_READ_BIT  = 12;
    localparam int CMD_WRITE_BIT = 13;
    localparam int CMD_ADDR_LSB  = 16;      // Address in 31:16
    localparam int ADDR_RW_BIT   = 15;      // Set selects read-write space
    localparam int ADDR_NOWR_BIT = 14;      // Set blocks the write

endpackage

`default_nettype wire

// ==== verilog/fifo_net_top.sv ====
// Host link packet router top
`default_nettype none

module fifo_net_top #(
    parameter logic [7:0] DEVICE_ID     = 8'd0,
    parameter logic [7:0] VERSION_MAJOR = 8'd0,
    parameter logic [7:0] VERSION_MINOR = 8'd0,
    parameter int         FIFO_DEPTH    = 16
) (
    input  wire         clk,
    input  wire         rst,
    // Host receive
    input  wire  [63:0] i_rx_data,
    input  wire         i_rx_valid,
    // TLP to PCIe, no back-pressure
    output logic [31:0] o_tlp_data,
    output logic        o_tlp_last,
    output logic        o_tlp_valid,
    // TLP from PCIe
    input  wire  [31:0] i_tlp_in_data,
    input  wire         i_tlp_in_last,
    input  wire         i_tlp_in_valid,
    output logic        o_tlp_in_ready,
    // Host transmit
    output logic [31:0] o_tx_data,
    output logic [1:0]  o_tx_ctx,
    output logic        o_tx_valid,
    input  wire         i_tx_ready,
    // PCIe identity
    output logic [15:0] o_subsys_vend_id,
    output logic [15:0] o_vend_id,
    output logic [15:0] o_dev_id,
    output logic [7:0]  o_rev_id
);

    word_stream_if #(.DW(fifo_net_pkg::TX_W)) tlp_s ();
    word_stream_if #(.DW(fifo_net_pkg::TX_W)) loop_s ();
    word_stream_if #(.DW(fifo_net_pkg::TX_W)) resp_s ();

    logic        loop_wr_en;
    logic [33:0] loop_din;
    logic        cmd_wr_en;
    logic [63:0] cmd_din;

    // PCIe TLP input as a stream
    assign tlp_s.data     = i_tlp_in_data;
    assign tlp_s.ctx      = {1'b0, i_tlp_in_last};
    assign tlp_s.valid    = i_tlp_in_valid;
    assign o_tlp_in_ready = tlp_s.ready;

    rx_router u_rx_router (
        .clk          (clk),
        .rst          (rst),
        .i_rx_data    (i_rx_data),
        .i_rx_valid   (i_rx_valid),
        .o_tlp_data   (o_tlp_data),
        .o_tlp_last   (o_tlp_last),
        .o_tlp_valid  (o_tlp_valid),
        .o_loop_wr_en (loop_wr_en),
        .o_loop_din   (loop_din),
        .o_cmd_wr_en  (cmd_wr_en),
        .o_cmd_din    (cmd_din)
    );

    sync_fifo #(.WIDTH(34), .DEPTH(FIFO_DEPTH)) u_loop_fifo (
        .clk           (clk),
        .rst           (rst),
        .i_wr_en       (loop_wr_en),
        .i_din         (loop_din),
        .o_full        (),
        .o_almost_full (),
        .out_s         (loop_s)
    );

    cmd_regfile #(
        .DEVICE_ID     (DEVICE_ID),
        .VERSION_MAJOR (VERSION_MAJOR),
        .VERSION_MINOR (VERSION_MINOR),
        .FIFO_DEPTH    (FIFO_DEPTH)
    ) u_cmd_regfile (
        .clk              (clk),
        .rst              (rst),
        .i_cmd_wr_en      (cmd_wr_en),
        .i_cmd_din        (cmd_din),
        .resp_s           (resp_s),
        .o_subsys_vend_id (o_subsys_vend_id),
        .o_vend_id        (o_vend_id),
        .o_dev_id         (o_dev_id),
        .o_rev_id         (o_rev_id)
    );

    tx_arbiter u_tx_arbiter (
        .clk        (clk),
        .rst        (rst),
        .tlp_s      (tlp_s),
        .loop_s     (loop_s),
        .resp_s     (resp_s),
        .o_tx_data  (o_tx_data),
        .o_tx_ctx   (o_tx_ctx),
        .o_tx_valid (o_tx_valid),
        .i_tx_ready (i_tx_ready)
    );

endmodule

`default_nettype wire

// ==== verilog/rx_router.sv ====
// Host word receive router
`default_nettype none

module rx_router (
    input  wire                           clk,
    input  wire                           rst,
    input  wire  [fifo_net_pkg::RX_W-1:0] i_rx_data,
    input  wire                           i_rx_valid,
    output logic [fifo_net_pkg::TX_W-1:0] o_tlp_data,
    output logic                          o_tlp_last,
    output logic                          o_tlp_valid,
    output logic                          o_loop_wr_en,
    output logic [33:0]                   o_loop_din,  // {ctx, payload}
    output logic                          o_cmd_wr_en,
    output logic [fifo_net_pkg::RX_W-1:0] o_cmd_din
);

    fifo_net_pkg::rx_type_e rx_type;
    logic                   accept;
    logic                   tlp_hit;
    logic                   loop_hit;
    logic                   cmd_hit;

    assign rx_type = fifo_net_pkg::rx_type_e'(i_rx_data[9:8]);
    assign accept  = i_rx_valid & (i_rx_data[7:0] == fifo_net_pkg::RX_MAGIC);

    // Type decode, bad magic hits nothing
    always_comb
    begin
        tlp_hit  = 1'b0;
        loop_hit = 1'b0;
        cmd_hit  = 1'b0;
        case (rx_type)
            fifo_net_pkg::RX_TLP:  tlp_hit  = accept;
            fifo_net_pkg::RX_LOOP: loop_hit = accept;
            fifo_net_pkg::RX_CMD:  cmd_hit  = accept;
            default:               ;                  // CFG words discarded
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            o_tlp_valid  <= 1'b0;
            o_loop_wr_en <= 1'b0;
            o_cmd_wr_en  <= 1'b0;
        end
        else
        begin
            o_tlp_valid  <= tlp_hit;
            o_loop_wr_en <= loop_hit;
            o_cmd_wr_en  <= cmd_hit;
        end
    end

    // Field split, loaded every cycle
    always_ff @(posedge clk)
    begin
        o_tlp_data <= i_rx_data[63:32];
        o_tlp_last <= i_rx_data[10];
        o_loop_din <= {i_rx_data[11:10], i_rx_data[63:32]};  // Context rides along
        o_cmd_din  <= i_rx_data;
    end

endmodule

`default_nettype wire

// ==== verilog/sync_fifo.sv ====
// First-word-fall-through FIFO
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 34,
    parameter int DEPTH = 16
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              i_wr_en,
    input  wire [WIDTH-1:0]  i_din,       // {ctx, data}
    output logic             o_full,
    output logic             o_almost_full,
    word_stream_if.source    out_s
);

    localparam int PW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);
    localparam int DW = WIDTH - fifo_net_pkg::CTX_W;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PW-1:0]    wr_ptr;
    logic [PW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic             push;
    logic             pop;

    // Pointer wrap, works for any depth
    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
        return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign push = i_wr_en & ~o_full;              // Full drops the word
    assign pop  = out_s.valid & out_s.ready;

    assign o_full        = (count == CW'(DEPTH));
    assign o_almost_full = (count >= CW'(DEPTH - 2)); // Room for one in flight

    // Head word shown straight from storage
    assign out_s.valid = (count != '0);
    assign out_s.data  = mem[rd_ptr][DW-1:0];
    assign out_s.ctx   = mem[rd_ptr][WIDTH-1 -: fifo_net_pkg::CTX_W];

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= i_din;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            // Occupancy
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/tx_arbiter.sv ====
// Fixed priority transmit arbiter
`default_nettype none

module tx_arbiter (
    input  wire         clk,
    input  wire         rst,
    word_stream_if.sink tlp_s,          // Highest priority
    word_stream_if.sink loop_s,
    word_stream_if.sink resp_s,         // Lowest priority
    output logic [31:0] o_tx_data,
    output logic [1:0]  o_tx_ctx,
    output logic        o_tx_valid,
    input  wire         i_tx_ready
);

    fifo_net_pkg::tx_src_e grant;
    logic                  load_en;

    // Output register free or leaving this cycle
    assign load_en = ~o_tx_valid | i_tx_ready;

    always_comb
    begin
        grant = fifo_net_pkg::SRC_NONE;
        if (load_en)
        begin
            if (tlp_s.valid)
                grant = fifo_net_pkg::SRC_TLP;
            else if (loop_s.valid)
                grant = fifo_net_pkg::SRC_LOOP;
            else if (resp_s.valid)
                grant = fifo_net_pkg::SRC_CMD;
        end
    end

    // Pop only the granted source
    assign tlp_s.ready  = (grant == fifo_net_pkg::SRC_TLP);
    assign loop_s.ready = (grant == fifo_net_pkg::SRC_LOOP);
    assign resp_s.ready = (grant == fifo_net_pkg::SRC_CMD);

    always_ff @(posedge clk)
    begin
        if (rst)
            o_tx_valid <= 1'b0;
        else if (load_en)
            o_tx_valid <= (grant != fifo_net_pkg::SRC_NONE);
    end

    // Data holds while stalled
    always_ff @(posedge clk)
    begin
        case (grant)
            fifo_net_pkg::SRC_TLP:
            begin
                o_tx_data <= tlp_s.data;
                o_tx_ctx  <= {1'b0, tlp_s.ctx[0]};   // Only last is kept
            end
            fifo_net_pkg::SRC_LOOP:
            begin
                o_tx_data <= loop_s.data;
                o_tx_ctx  <= loop_s.ctx;
            end
            fifo_net_pkg::SRC_CMD:
            begin
                o_tx_data <= resp_s.data;
                o_tx_ctx  <= resp_s.ctx;
            end
            default:
            begin
                o_tx_data <= o_tx_data;
                o_tx_ctx  <= o_tx_ctx;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/word_stream_if.sv ====
// Valid/ready word stream
`default_nettype none

interface word_stream_if #(
    parameter int DW = 32
) ();

    logic [DW-1:0]                  data;
    logic [fifo_net_pkg::CTX_W-1:0] ctx;    // Travels with data
    logic                           valid;  // Held until accepted
    logic                           ready;

    // Transfer on an edge with valid and ready high
    modport source (
        output data,
        output ctx,
        output valid,
        input  ready
    );

    modport sink (
        input  data,
        input  ctx,
        input  valid,
        output ready
    );

endinterface

`default_nettype wire
